// File: all.f
source/trap_pkg.sv
source/csr_if.sv
source/trap_decode.sv
source/trap_sequencer.sv
source/csr_file.sv
source/trap_unit_top.sv
tb/trap_unit_tb.sv

// File: source/csr_file.sv
// ------------------------------
// core port writes dropped while a trap holds the bus
// ------------------------------
`timescale 1ns/1ns

module csr_file (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_csr_we,
  input  logic [11:0] i_csr_addr,
  input  logic [63:0] i_csr_wdata,
  output logic [63:0] o_csr_rdata,
  csr_if.csr          bus
);

  logic [63:0]        mepc_q;
  logic [63:0]        mcause_q;
  logic [63:0]        mtvec_q;
  trap_pkg::mstatus_u mstatus_q;

  logic               seq_active;
  logic               wr_en;
  logic [11:0]        wr_addr;
  logic [63:0]        wr_data;

  function automatic logic [63:0] read_csr(input logic [11:0] addr);
    case (addr)
      trap_pkg::csr_mepc:    read_csr = mepc_q;
      trap_pkg::csr_mcause:  read_csr = mcause_q;
      trap_pkg::csr_mtvec:   read_csr = mtvec_q;
      trap_pkg::csr_mstatus: read_csr = mstatus_q.raw;
      default:               read_csr = 64'd0;
    endcase
  endfunction

  // sequencer wins the write port
  assign seq_active = bus.ren || bus.wen;
  assign wr_en      = seq_active ? bus.wen   : i_csr_we;
  assign wr_addr    = seq_active ? bus.addr  : i_csr_addr;
  assign wr_data    = seq_active ? bus.wdata : i_csr_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      mepc_q        <= trap_pkg::pc_reset;
      mcause_q      <= trap_pkg::pc_reset;
      mtvec_q       <= trap_pkg::pc_reset;
      mstatus_q.raw <= trap_pkg::pc_reset;
    end else if (wr_en) begin
      case (wr_addr)
        trap_pkg::csr_mepc: begin
          mepc_q <= wr_data;
        end
        trap_pkg::csr_mcause: begin
          mcause_q <= wr_data;
        end
        trap_pkg::csr_mtvec: begin
          mtvec_q <= {wr_data[63:2], 2'b00};  // direct mode only
        end
        trap_pkg::csr_mstatus: begin
          mstatus_q.raw <= wr_data;
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    bus.rdata   = bus.ren ? read_csr(bus.addr) : 64'd0;
    o_csr_rdata = read_csr(i_csr_addr);
  end

  a_core_wr_blocked: assert property (@(posedge clk) disable iff (rst)
    !(i_csr_we && seq_active));

endmodule

// File: source/csr_if.sv
// ------------------------------
// rdata valid only while ren is high
// ------------------------------
`timescale 1ns/1ns

interface csr_if;
  logic [11:0] addr;
  logic        ren;
  logic        wen;
  logic [63:0] wdata;
  logic [63:0] rdata;

  modport sequencer (
    output addr,
    output ren,
    output wen,
    output wdata,
    input  rdata
  );

  modport csr (
    input  addr,
    input  ren,
    input  wen,
    input  wdata,
    output rdata
  );
endinterface

// File: source/trap_decode.sv
// ------------------------------
// one-entry slot, events that are not traps are dropped
// ------------------------------
`timescale 1ns/1ns

module trap_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_valid,
  input  logic [7:0]            i_opcode,
  input  logic [63:0]           i_pc,
  input  logic                  i_timer_irq,
  input  logic                  i_take,
  output logic                  o_ready,
  output logic                  o_pending,
  output trap_pkg::trap_kind_e  o_kind,
  output logic [63:0]           o_cause,
  output logic [63:0]           o_pc
);

  trap_pkg::trap_kind_e kind_in;
  logic [63:0]          cause_in;
  logic                 pending_q;
  logic                 fill;

  always_comb begin
    kind_in  = trap_pkg::none;
    cause_in = 64'd0;
    if (i_opcode == trap_pkg::op_ecall) begin
      kind_in  = trap_pkg::enter;
      cause_in = trap_pkg::cause_ecall_m;
    end else if (i_opcode == trap_pkg::op_mret) begin
      kind_in = trap_pkg::leave;
    end else if (i_timer_irq) begin
      kind_in  = trap_pkg::enter;
      cause_in = trap_pkg::cause_timer_m;
    end
  end

  assign fill = i_valid && o_ready && (kind_in != trap_pkg::none);

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else if (i_take) begin
      pending_q <= 1'b0;
    end else if (fill) begin
      pending_q <= 1'b1;
    end
  end

  // inputs last one cycle only
  always_ff @(posedge clk) begin
    if (fill) begin
      o_kind  <= kind_in;
      o_cause <= cause_in;
      o_pc    <= i_pc;
    end
  end

  assign o_ready   = !pending_q;
  assign o_pending = pending_q;

  a_take_needs_item: assert property (@(posedge clk) disable iff (rst)
    i_take |-> pending_q);

endmodule

// File: source/trap_pkg.sv
// ------------------------------
// machine mode only, direct mtvec mode, no mie/mip masking
// ------------------------------
package trap_pkg;

  // retired opcodes that trap
  localparam logic [7:0] op_ecall = 8'h73;
  localparam logic [7:0] op_mret  = 8'h30;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  localparam logic [63:0] cause_ecall_m = 64'd11;
  localparam logic [63:0] cause_timer_m = 64'h8000_0000_0000_0007; // interrupt bit, code 7

  localparam logic [63:0] pc_reset = 64'd0;

  // sequencer states, one per CSR access
  localparam logic [3:0] st_idle       = 4'd0;
  localparam logic [3:0] st_ent_mepc   = 4'd1;
  localparam logic [3:0] st_ent_mcause = 4'd2;
  localparam logic [3:0] st_ent_mtvec  = 4'd3;
  localparam logic [3:0] st_ent_mst_rd = 4'd4;
  localparam logic [3:0] st_ent_mst_wr = 4'd5;
  localparam logic [3:0] st_lv_mst_rd  = 4'd6;
  localparam logic [3:0] st_lv_mepc    = 4'd7;
  localparam logic [3:0] st_lv_mst_wr  = 4'd8;

  typedef enum logic [1:0] {
    none  = 2'd0,
    enter = 2'd1,
    leave = 2'd2
  } trap_kind_e;

  typedef struct packed {
    logic [50:0] hi;
    logic [1:0]  mpp;    // [12:11]
    logic [2:0]  mid_hi;
    logic        mpie;   // [7]
    logic [2:0]  mid_lo;
    logic        mie;    // [3]
    logic [2:0]  lo;
  } mstatus_f_t;

  typedef union packed {
    logic [63:0] raw;
    mstatus_f_t  f;
  } mstatus_u;

endpackage

// File: source/trap_sequencer.sv
// ------------------------------
// one CSR access at a time, 3 cycles each
// no new item while o_req waits for i_ack
// ------------------------------
`timescale 1ns/1ns

module trap_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_pending,
  input  trap_pkg::trap_kind_e  i_kind,
  input  logic [63:0]           i_cause,
  input  logic [63:0]           i_pc,
  input  logic                  i_ack,
  output logic                  o_take,
  output logic                  o_req,
  output logic                  o_pc_jmp,
  output logic [63:0]           o_pc_jmpaddr,
  csr_if.sequencer              bus
);

  logic [3:0]         state;
  logic [3:0]         next_state;
  logic [1:0]         step;
  logic [63:0]        pc_q;
  logic [63:0]        cause_q;
  logic [63:0]        target_q;    // mtvec or mepc
  trap_pkg::mstatus_u status_q;
  trap_pkg::mstatus_u enter_st;
  trap_pkg::mstatus_u leave_st;

  logic [11:0]        acc_addr;
  logic               acc_write;
  logic [63:0]        acc_wdata;
  logic               acc_target;
  logic               acc_last;

  assign o_take = (state == trap_pkg::st_idle) && i_pending && !o_req;

  always_comb begin
    enter_st        = status_q;
    enter_st.f.mpp  = 2'b11;
    enter_st.f.mpie = status_q.f.mie;
    enter_st.f.mie  = 1'b0;

    leave_st        = status_q;
    leave_st.f.mpp  = 2'b00;
    leave_st.f.mpie = 1'b1;
    leave_st.f.mie  = status_q.f.mpie;
  end

  // what the current state accesses
  always_comb begin
    acc_addr   = trap_pkg::csr_mstatus;
    acc_write  = 1'b0;
    acc_wdata  = enter_st.raw;
    acc_target = 1'b0;
    acc_last   = 1'b0;
    next_state = trap_pkg::st_idle;
    case (state)
      trap_pkg::st_ent_mepc: begin
        acc_addr   = trap_pkg::csr_mepc;
        acc_write  = 1'b1;
        acc_wdata  = pc_q;
        next_state = trap_pkg::st_ent_mcause;
      end
      trap_pkg::st_ent_mcause: begin
        acc_addr   = trap_pkg::csr_mcause;
        acc_write  = 1'b1;
        acc_wdata  = cause_q;
        next_state = trap_pkg::st_ent_mtvec;
      end
      trap_pkg::st_ent_mtvec: begin
        acc_addr   = trap_pkg::csr_mtvec;
        acc_target = 1'b1;
        next_state = trap_pkg::st_ent_mst_rd;
      end
      trap_pkg::st_ent_mst_rd: begin
        next_state = trap_pkg::st_ent_mst_wr;
      end
      trap_pkg::st_ent_mst_wr: begin
        acc_write = 1'b1;
        acc_last  = 1'b1;
      end
      trap_pkg::st_lv_mst_rd: begin
        next_state = trap_pkg::st_lv_mepc;
      end
      trap_pkg::st_lv_mepc: begin
        acc_addr   = trap_pkg::csr_mepc;
        acc_target = 1'b1;
        next_state = trap_pkg::st_lv_mst_wr;
      end
      trap_pkg::st_lv_mst_wr: begin
        acc_write = 1'b1;
        acc_wdata = leave_st.raw;
        acc_last  = 1'b1;
      end
      default: begin
        next_state = trap_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= trap_pkg::st_idle;
      step     <= 2'd0;
      o_req    <= 1'b0;
      o_pc_jmp <= 1'b0;
      bus.ren  <= 1'b0;
      bus.wen  <= 1'b0;
    end else begin
      o_pc_jmp <= 1'b0;
      if (o_req && i_ack) begin
        o_req <= 1'b0;
      end
      if (state == trap_pkg::st_idle) begin
        step <= 2'd0;
        if (o_take) begin
          if (i_kind == trap_pkg::leave) begin
            state <= trap_pkg::st_lv_mst_rd;
          end else begin
            state <= trap_pkg::st_ent_mepc;
          end
        end
      end else begin
        case (step)
          2'd0: begin                 // gap, issue request
            bus.ren <= !acc_write;
            bus.wen <= acc_write;
            step    <= 2'd1;
          end
          2'd1: begin                 // request cycle
            bus.ren <= 1'b0;
            bus.wen <= 1'b0;
            step    <= 2'd2;
            if (acc_last) begin
              o_pc_jmp <= 1'b1;
            end
          end
          default: begin              // release cycle
            state <= next_state;
            step  <= 2'd0;
            if (acc_last) begin
              o_req <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_take) begin
      pc_q    <= i_pc;
      cause_q <= i_cause;
    end
    if (state != trap_pkg::st_idle && step == 2'd0) begin
      bus.addr  <= acc_addr;
      bus.wdata <= acc_wdata;
    end
    if (step == 2'd1 && bus.ren) begin
      if (acc_target) begin
        target_q <= bus.rdata;
      end else begin
        status_q.raw <= bus.rdata;
      end
    end
  end

  assign o_pc_jmpaddr = target_q;

  a_ren_wen_excl: assert property (@(posedge clk) disable iff (rst)
    !(bus.ren && bus.wen));

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    o_req && !i_ack |=> o_req);

  a_jmp_pulse: assert property (@(posedge clk) disable iff (rst)
    o_pc_jmp |=> !o_pc_jmp);

endmodule

// File: source/trap_unit_top.sv
// ------------------------------
// wiring only, adds no latency
// ------------------------------
`timescale 1ns/1ns

module trap_unit_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_valid,
  input  logic [7:0]  i_opcode,
  input  logic [63:0] i_pc,
  input  logic        i_timer_irq,
  input  logic        i_ack,
  input  logic        i_csr_we,
  input  logic [11:0] i_csr_addr,
  input  logic [63:0] i_csr_wdata,
  output logic        o_ready,
  output logic        o_req,
  output logic        o_pc_jmp,
  output logic [63:0] o_pc_jmpaddr,
  output logic [63:0] o_csr_rdata
);

  trap_pkg::trap_kind_e kind;
  logic [63:0]          cause;
  logic [63:0]          pc;
  logic                 pending;
  logic                 take;

  csr_if csr_bus ();

  trap_decode i_trap_decode (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (i_valid),
    .i_opcode    (i_opcode),
    .i_pc        (i_pc),
    .i_timer_irq (i_timer_irq),
    .i_take      (take),
    .o_ready     (o_ready),
    .o_pending   (pending),
    .o_kind      (kind),
    .o_cause     (cause),
    .o_pc        (pc)
  );

  trap_sequencer i_trap_sequencer (
    .clk          (clk),
    .rst          (rst),
    .i_pending    (pending),
    .i_kind       (kind),
    .i_cause      (cause),
    .i_pc         (pc),
    .i_ack        (i_ack),
    .o_take       (take),
    .o_req        (o_req),
    .o_pc_jmp     (o_pc_jmp),
    .o_pc_jmpaddr (o_pc_jmpaddr),
    .bus          (csr_bus.sequencer)
  );

  csr_file i_csr_file (
    .clk         (clk),
    .rst         (rst),
    .i_csr_we    (i_csr_we),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata),
    .bus         (csr_bus.csr)
  );

endmodule

// File: tb/trap_unit_tb.sv
// ------------------------------
// trap_unit_top with ecall, mret, timer and queued events; core port writes only when idle
// ------------------------------
`timescale 1ns/1ns

module trap_unit_tb;
  logic        clk;
  logic        rst;
  logic        i_valid;
  logic [7:0]  i_opcode;
  logic [63:0] i_pc;
  logic        i_timer_irq;
  logic        i_ack;
  logic        i_csr_we;
  logic [11:0] i_csr_addr;
  logic [63:0] i_csr_wdata;
  logic        o_ready;
  logic        o_req;
  logic        o_pc_jmp;
  logic [63:0] o_pc_jmpaddr;
  logic [63:0] o_csr_rdata;

  localparam int n_events   = 14;
  localparam int max_cycles = n_events * (18 + 8) + 50;

  logic [63:0] rng       = 64'd48;
  logic [63:0] m_mepc    = 64'd0;  // reference CSR state
  logic [63:0] m_mcause  = 64'd0;
  logic [63:0] m_mtvec   = 64'd0;
  logic [63:0] m_mstatus = 64'd0;
  int          errors    = 0;
  int          n_pass    = 0;
  int          n_fail    = 0;

  trap_unit_top i_trap_unit_top (.*);

  always #50 clk = ~clk;

  initial begin
    repeat (max_cycles) @(posedge clk);
    $display("timeout: run hung, no progress after %0d cycles", max_cycles);
    $display("sim failed");
    $finish;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  a_req_hold: assert property (@(posedge clk) disable iff (rst) o_req && !i_ack |=> o_req)
    else report_error("o_req fell before i_ack");
  a_req_release: assert property (@(posedge clk) disable iff (rst) o_req && i_ack |=> !o_req)
    else report_error("o_req stayed high after i_ack");
  a_jmp_then_req: assert property (@(posedge clk) disable iff (rst) o_pc_jmp |=> o_req)
    else report_error("o_pc_jmp was not followed by o_req");
  a_no_jmp_in_req: assert property (@(posedge clk) disable iff (rst) !(o_pc_jmp && o_req))
    else report_error("o_pc_jmp came while o_req was high");

  function automatic logic [63:0] xorshift64(input logic [63:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    return x ^ (x << 17);
  endfunction

  function automatic logic [63:0] rand64();
    rng = xorshift64(rng);
    return rng;
  endfunction

  // mie bit 3, mpie bit 7, mpp bits 12:11
  function automatic logic [63:0] trap_status(input logic [63:0] old, input logic entering);
    logic [63:0] s;
    s        = old;
    s[12:11] = entering ? 2'b11 : 2'b00;
    s[7]     = entering ? old[3] : 1'b1;
    s[3]     = entering ? 1'b0 : old[7];
    return s;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    assert (got === exp)
      else report_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic core_write(input logic [11:0] addr, input logic [63:0] data);
    @(posedge clk);
    i_csr_we    <= 1'b1;
    i_csr_addr  <= addr;
    i_csr_wdata <= data;
    @(posedge clk);
    i_csr_we <= 1'b0;
  endtask

  task automatic check_csr(input logic [11:0] addr, input logic [63:0] exp, input string name);
    @(posedge clk);
    i_csr_addr <= addr;
    @(negedge clk);
    check_val(name, o_csr_rdata, exp);
  endtask

  task automatic send_event(input logic [7:0] op, input logic [63:0] pc, input logic irq);
    @(posedge clk);
    i_valid     <= 1'b1;
    i_opcode    <= op;
    i_pc        <= pc;
    i_timer_irq <= irq;
    @(posedge clk);
    i_valid     <= 1'b0;
    i_timer_irq <= 1'b0;
  endtask

  task automatic expect_redirect(input logic [63:0] target);
    @(negedge clk);
    while (!o_pc_jmp) @(negedge clk);
    check_val("o_pc_jmpaddr", o_pc_jmpaddr, target);
  endtask

  task automatic ack_request(input logic queued);
    int delay;
    delay = int'(rand64() % 8);  // 0 to 7 cycles
    repeat (delay + 1) begin
      @(negedge clk);
      check_val("o_req", o_req, 1'b1);
      if (queued)
        check_val("o_ready", o_ready, 1'b0);
    end
    @(posedge clk);
    i_ack <= 1'b1;
    @(posedge clk);
    i_ack <= 1'b0;
    @(negedge clk);
    check_val("o_req", o_req, 1'b0);
  endtask

  task automatic run_entry(input logic [7:0] op, input logic irq, input logic [63:0] cause);
    logic [63:0] pc;
    pc = rand64() & ~64'h3;
    send_event(op, pc, irq);
    @(negedge clk);
    check_val("o_ready", o_ready, 1'b0);
    expect_redirect(m_mtvec);
    m_mepc    = pc;
    m_mcause  = cause;
    m_mstatus = trap_status(m_mstatus, 1'b1);
    ack_request(1'b0);
    check_csr(trap_pkg::csr_mepc, m_mepc, "mepc");
    check_csr(trap_pkg::csr_mcause, m_mcause, "mcause");
    check_csr(trap_pkg::csr_mstatus, m_mstatus, "mstatus");
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      n_pass++;
      $display("test %s: pass", name);
    end else begin
      n_fail++;
      $display("test %s: fail with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    logic [7:0]         op;
    logic [63:0]        r;
    int                 mark;
    trap_pkg::mstatus_u st;
    clk         = 1'b0;
    rst         = 1'b1;
    i_valid     = 1'b0;
    i_opcode    = 8'd0;
    i_pc        = 64'd0;
    i_timer_irq = 1'b0;
    i_ack       = 1'b0;
    i_csr_we    = 1'b0;
    i_csr_addr  = 12'd0;
    i_csr_wdata = 64'd0;
    repeat (10) @(posedge clk);
    rst  <= 1'b0;
    mark = errors;
    @(negedge clk);
    check_val("o_ready", o_ready, 1'b1);
    check_val("o_req", o_req, 1'b0);
    check_val("o_pc_jmp", o_pc_jmp, 1'b0);
    end_test("reset", mark);

    mark = errors;
    r    = rand64();
    core_write(trap_pkg::csr_mtvec, r);
    m_mtvec = {r[63:2], 2'b00};  // direct mode
    run_entry(trap_pkg::op_ecall, 1'b0, trap_pkg::cause_ecall_m);
    end_test("ecall_entry", mark);

    mark = errors;
    repeat (3) begin
      st.raw = rand64();
      core_write(trap_pkg::csr_mstatus, st.raw);
      m_mstatus = st.raw;
      run_entry(trap_pkg::op_ecall, 1'b0, trap_pkg::cause_ecall_m);
      check_val("mstatus.mpie", o_csr_rdata[7], st.f.mie);
    end
    end_test("entry_mstatus", mark);

    mark = errors;
    repeat (2) begin
      st.raw = rand64();
      core_write(trap_pkg::csr_mstatus, st.raw);
      m_mstatus = st.raw;
      send_event(trap_pkg::op_mret, rand64(), 1'b0);
      expect_redirect(m_mepc);
      m_mstatus = trap_status(m_mstatus, 1'b0);
      ack_request(1'b0);
      check_csr(trap_pkg::csr_mstatus, m_mstatus, "mstatus");
      check_val("mstatus.mie", o_csr_rdata[3], st.f.mpie);
    end
    end_test("mret", mark);

    mark = errors;
    op   = 8'(rand64());
    if (op == trap_pkg::op_ecall || op == trap_pkg::op_mret)
      op = 8'h13;
    run_entry(op, 1'b1, trap_pkg::cause_timer_m);
    end_test("timer_irq", mark);

    mark = errors;
    send_event(op, rand64(), 1'b0);
    repeat (20) begin  // longer than a full entry sequence
      @(negedge clk);
      check_val("o_pc_jmp", o_pc_jmp, 1'b0);
      check_val("o_req", o_req, 1'b0);
      check_val("o_ready", o_ready, 1'b1);
    end
    end_test("ignored_event", mark);

    mark = errors;
    repeat (3) begin
      r = rand64() & ~64'h3;
      send_event(trap_pkg::op_ecall, r, 1'b0);
      @(negedge clk);
      while (!o_ready) @(negedge clk);
      send_event(trap_pkg::op_mret, rand64(), 1'b0);  // queued behind the ecall
      expect_redirect(m_mtvec);
      check_val("o_ready", o_ready, 1'b0);
      m_mepc    = r;
      m_mcause  = trap_pkg::cause_ecall_m;
      m_mstatus = trap_status(m_mstatus, 1'b1);
      ack_request(1'b1);
      expect_redirect(m_mepc);
      m_mstatus = trap_status(m_mstatus, 1'b0);
      ack_request(1'b0);
      check_csr(trap_pkg::csr_mstatus, m_mstatus, "mstatus");
    end
    end_test("back_to_back", mark);

    $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
